/* list.f */
+incdir+verif
common/intt_pkg.sv
common/coef_mem_if.sv
logic/coef_loader.sv
logic/coef_store.sv
scale/scale_unloader.sv
logic/intt_top.sv
verif/intt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the inverse-NTT testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module intt_tb -o intt_sim \
    > build.log 2>&1 \
    && ./obj_dir/intt_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null

[ -s sim.log ] && ! grep -q "Errors found" sim.log && grep -q "No errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* verif/intt_tests.svh */
`ifndef INTT_TESTS_SVH
`define INTT_TESTS_SVH

// serial load of ref_in, with an optional unload pulse at sample poke
task automatic load_coefs(input string test, input int poke);
    @(negedge clk);
    load = 1'b1;
    @(negedge clk);                 // accepted on the edge in between
    load = 1'b0;
    for (int j = 0; j < N; j++) begin
        din    = ref_in[j];
        unload = (j == poke);
        if (dout_valid) begin
            report_failure(test, "dout_valid went high while a load was running");
        end
        @(negedge clk);
    end
    unload = 1'b0;
endtask

// unload pulse, then capture the stream; optional load pulse at word poke
task automatic unload_stream(input string test, input int poke);
    @(negedge clk);
    unload = 1'b1;
    @(negedge clk);
    unload    = 1'b0;
    got_len   = 0;
    first_lat = 0;
    while (!dout_valid && first_lat < N + 8) begin
        @(negedge clk);
        first_lat++;
    end
    if (!dout_valid) begin
        report_failure(test, "dout_valid never rose after the unload pulse");
        return;
    end
    while (dout_valid && got_len <= N + 4) begin
        if (got_len < N) begin
            got[got_len] = dout;
        end
        got_len++;
        if (done) begin
            report_failure(test, "done was high together with dout_valid");
        end
        load = (got_len == poke);
        if (load) begin
            din = lcg_coef();       // would land in the banks if the load were taken
        end
        @(negedge clk);
    end
    load = 1'b0;
    if (!done) begin
        report_failure(test, "done did not pulse on the cycle after the last word");
    end
    @(negedge clk);
    if (done) begin
        report_failure(test, "done stayed high for more than one cycle");
    end
endtask

task automatic compare_stream(input string test);
    check_value({test, " length"}, N, got_len);
    for (int k = 0; k < N && k < got_len; k++) begin
        check_value(test, expect_word(k), int'(got[k]));
    end
endtask

// no output activity for a while
task automatic expect_quiet(input string test, input int n_cycles);
    for (int i = 0; i < n_cycles; i++) begin
        @(negedge clk);
        if (dout_valid || done) begin
            report_failure(test, "output activity seen with no unload running");
        end
    end
endtask

task automatic ramp_load_unload();
    for (int j = 0; j < N; j++) begin
        ref_in[j] = intt_pkg::coef_t'(j);
    end
    load_coefs("ramp", -1);
    unload_stream("ramp", -1);
    compare_stream("ramp");
endtask

task automatic random_load_unload();
    for (int j = 0; j < N; j++) begin
        ref_in[j] = lcg_coef();
    end
    load_coefs("random", -1);
    unload_stream("random", -1);
    compare_stream("random");
endtask

task automatic repeated_unload();
    intt_pkg::coef_t first [N];
    int first_len;
    unload_stream("repeat", -1);
    first     = got;
    first_len = got_len;
    unload_stream("repeat", -1);
    check_value("repeat length", first_len, got_len);
    for (int k = 0; k < N; k++) begin
        check_value("repeat", int'(first[k]), int'(got[k]));
    end
    compare_stream("repeat");
endtask

task automatic ignored_pulses();
    for (int j = 0; j < N; j++) begin
        ref_in[j] = lcg_coef();
    end
    load_coefs("ignored", N / 2);       // unload pulse mid-load
    expect_quiet("ignored", 8);
    unload_stream("ignored", N / 2);    // load pulse mid-unload
    compare_stream("ignored");
    expect_quiet("ignored", N + 4);     // a taken load would also be quiet, next unload shows it
    unload_stream("ignored reread", -1);
    compare_stream("ignored reread");
endtask

task automatic output_latency();
    unload_stream("latency", -1);
    check_value("latency first valid", 4, first_lat);   // 1 + 1 + two multiply stages
    check_value("latency run length", N, got_len);
endtask

task automatic reset_mid_unload();
    int n;
    @(negedge clk);
    unload = 1'b1;
    @(negedge clk);
    unload = 1'b0;
    n      = 0;
    while (!dout_valid && n < N + 8) begin
        @(negedge clk);
        n++;
    end
    if (!dout_valid) begin
        report_failure("reset", "dout_valid never rose before the reset");
    end
    repeat (N / 2) @(negedge clk);
    reset = 1'b1;
    #1;                              // async reset, outputs fall at once
    check_value("reset dout_valid", 0, int'(dout_valid));
    check_value("reset done", 0, int'(done));
    repeat (3) @(negedge clk);
    reset = 1'b0;
    expect_quiet("reset", 4);
    for (int j = 0; j < N; j++) begin
        ref_in[j] = lcg_coef();
    end
    load_coefs("reset reload", -1);
    unload_stream("reset reload", -1);
    compare_stream("reset reload");
endtask

`endif

/* verif/intt_tb.sv */
`timescale 1ns/1ps

module intt_tb;

    localparam int RING_DEPTH = 5;
    localparam int N          = 1 << RING_DEPTH;
    localparam int Q          = 7681;
    localparam int N_INV      = 7441;                     // 32^-1 mod 7681
    localparam int NUM_TESTS  = 6;
    localparam int MAX_CYCLES = NUM_TESTS * 8 * (N + 10);  // watchdog limit

    logic            clk;
    logic            reset;
    logic            load;
    intt_pkg::coef_t din;
    logic            unload;
    intt_pkg::coef_t dout;
    logic            dout_valid;
    logic            done;

    int              errors;
    int              checks;
    int              cycles = 0;
    logic [31:0]     lcg_state;
    intt_pkg::coef_t ref_in [N];   // words in load order
    intt_pkg::coef_t got [N];      // last captured output stream
    int              got_len;
    int              first_lat;    // cycles from the unload edge to the first valid word

    intt_top #(.RING_DEPTH(RING_DEPTH), .Q(Q), .N_INV(N_INV)) intt_top_i (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .din        (din),
        .unload     (unload),
        .dout       (dout),
        .dout_valid (dout_valid),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic intt_pkg::coef_t lcg_coef();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return intt_pkg::coef_t'(lcg_state[31:8] % Q);   // upper bits, reduced below Q
    endfunction

    function automatic int bitrev(input int k);
        int r;
        r = 0;
        for (int i = 0; i < RING_DEPTH; i++) begin
            r = (r << 1) | ((k >> i) & 1);
        end
        return r;
    endfunction

    // model: word k is the sample loaded at bitrev(k), scaled by 1/N
    function automatic int expect_word(input int k);
        return int'((longint'(ref_in[bitrev(k)]) * N_INV) % Q);
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error [%s]: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic report_failure(input string test, input string what);
        errors++;
        $display("[%s] %s", test, what);
    endtask

    `include "intt_tests.svh"

    initial begin
        reset     = 1'b1;
        load      = 1'b0;
        din       = '0;
        unload    = 1'b0;
        errors    = 0;
        checks    = 0;
        got_len   = 0;
        first_lat = 0;
        lcg_state = 32'h270c_4bdf;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        ramp_load_unload();
        random_load_unload();
        repeated_unload();
        ignored_pulses();
        output_latency();
        reset_mid_unload();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* logic/intt_top.sv */
`timescale 1ns/1ps

// serial inverse-NTT data path
// bit-reversed load, then unload with the 1/N scaling
module intt_top #(
    parameter int RING_DEPTH = 5,     // N = 2^RING_DEPTH
    parameter int Q          = 7681,
    parameter int N_INV      = 7441   // N^-1 mod Q
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  intt_pkg::coef_t   din,
    input  logic              unload,
    output intt_pkg::coef_t   dout,
    output logic              dout_valid,
    output logic              done
);

    logic load_busy;     // loader run in progress
    logic unload_busy;   // unloader read or drain in progress

    coef_mem_if #(.ADDR_WIDTH(RING_DEPTH)) mem ();

    coef_loader #(.RING_DEPTH(RING_DEPTH)) coef_loader_i (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .din         (din),
        .unload_busy (unload_busy),
        .load_busy   (load_busy),
        .mem         (mem.writer)
    );

    coef_store #(.RING_DEPTH(RING_DEPTH)) coef_store_i (
        .clk (clk),
        .mem (mem.store)
    );

    scale_unloader #(.RING_DEPTH(RING_DEPTH), .Q(Q), .N_INV(N_INV)) scale_unloader_i (
        .clk         (clk),
        .reset       (reset),
        .unload      (unload),
        .load_busy   (load_busy),
        .unload_busy (unload_busy),
        .dout        (dout),
        .dout_valid  (dout_valid),
        .done        (done),
        .mem         (mem.reader)
    );

endmodule

/* scale/scale_unloader.sv */
`timescale 1ns/1ps

// serial unloader with the final 1/N scaling of the inverse NTT
// words leave in storage order, each multiplied by N_INV mod Q
module scale_unloader #(
    parameter int RING_DEPTH = 5,
    parameter int Q          = 7681,
    parameter int N_INV      = 7441
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              unload,       // one-cycle start pulse
    input  logic              load_busy,
    output logic              unload_busy,
    output intt_pkg::coef_t   dout,
    output logic              dout_valid,
    output logic              done,         // one cycle after the last word
    coef_mem_if.reader        mem
);

    localparam int N      = 1 << RING_DEPTH;
    localparam int PROD_W = 2 * intt_pkg::COEF_WIDTH;

    intt_pkg::unload_state_e   state;
    logic [RING_DEPTH-1:0]     cnt;        // read index, then drain count
    logic [RING_DEPTH-1:0]     raddr_q;    // address register toward the banks
    logic                      rd_valid;   // raddr_q holds a live address
    logic                      mem_valid;  // rdata holds a live word
    logic                      mul_valid;  // prod holds a live product
    logic [PROD_W-1:0]         prod;

    // control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= intt_pkg::unload_idle;
            cnt   <= '0;
        end else begin
            case (state)
                intt_pkg::unload_idle: begin
                    cnt <= '0;
                    if (unload && !load_busy) begin   // loader must be quiet
                        state <= intt_pkg::unload_read;
                    end
                end
                intt_pkg::unload_read: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == RING_DEPTH'(N - 1)) begin
                        state <= intt_pkg::unload_drain;
                        cnt   <= '0;
                    end
                end
                intt_pkg::unload_drain: begin
                    // MUL_LATENCY + 1 cycles, the read stage plus the multiply
                    cnt <= cnt + 1'b1;
                    if (cnt == RING_DEPTH'(intt_pkg::MUL_LATENCY)) begin
                        state <= intt_pkg::unload_idle;
                    end
                end
                default: state <= intt_pkg::unload_idle;
            endcase
        end
    end

    assign unload_busy = (state != intt_pkg::unload_idle);

    // valid bits, one per pipeline stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            mem_valid  <= 1'b0;
            mul_valid  <= 1'b0;
            dout_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            rd_valid   <= (state == intt_pkg::unload_read);
            mem_valid  <= rd_valid;
            mul_valid  <= mem_valid;
            dout_valid <= mul_valid;
            done       <= dout_valid && !mul_valid;   // last word leaving
        end
    end

    // data path: address, product, reduction
    always_ff @(posedge clk) begin
        raddr_q <= cnt;
        prod    <= PROD_W'(mem.rdata) * PROD_W'(N_INV);
        dout    <= intt_pkg::coef_t'(prod % PROD_W'(Q));
    end

    assign mem.raddr = raddr_q;

    // done comes strictly after the stream
    a_done_excl: assert property (@(posedge clk) disable iff (reset)
        done |-> !dout_valid)
        else $error("scale_unloader: done overlaps dout_valid");

    // output is fully reduced
    a_dout_range: assert property (@(posedge clk) disable iff (reset)
        dout_valid |-> (dout < intt_pkg::coef_t'(Q)))
        else $error("scale_unloader: dout not below Q");

endmodule

/* logic/coef_store.sv */
`timescale 1ns/1ps

// coefficient store, an even bank and an odd bank of N/2 words each
// address bit 0 picks the bank, the upper bits pick the row
module coef_store #(
    parameter int RING_DEPTH = 5
) (
    input  logic        clk,
    coef_mem_if.store   mem
);

    localparam int ROWS = 1 << (RING_DEPTH - 1);

    intt_pkg::coef_t bank_even [ROWS];  // addresses with bit 0 clear
    intt_pkg::coef_t bank_odd  [ROWS];  // addresses with bit 0 set

    intt_pkg::coef_t   even_q;    // registered read of each bank
    intt_pkg::coef_t   odd_q;
    logic              rsel_q;    // bank select, aligned with the read data

    // write port, one bank per strobe
    always_ff @(posedge clk) begin
        if (mem.wen) begin
            if (mem.waddr[0]) begin
                bank_odd[mem.waddr[RING_DEPTH-1:1]] <= mem.wdata;
            end else begin
                bank_even[mem.waddr[RING_DEPTH-1:1]] <= mem.wdata;
            end
        end
    end

    // read port
    // both banks read the same row, the delayed select steers rdata
    always_ff @(posedge clk) begin
        even_q <= bank_even[mem.raddr[RING_DEPTH-1:1]];
        odd_q  <= bank_odd[mem.raddr[RING_DEPTH-1:1]];
        rsel_q <= mem.raddr[0];
    end

    assign mem.rdata = rsel_q ? odd_q : even_q;   // valid one cycle after raddr

    // the loader must hand over a clean address with every write
    a_waddr_known: assert property (@(posedge clk)
        mem.wen |-> !$isunknown(mem.waddr))
        else $error("coef_store: write address has unknown bits");

endmodule

/* logic/coef_loader.sv */
`timescale 1ns/1ps

// serial coefficient loader
// sample j of a run lands at address bitrev(j), one per cycle
module coef_loader #(
    parameter int RING_DEPTH = 5
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,         // one-cycle start pulse
    input  intt_pkg::coef_t   din,
    input  logic              unload_busy,
    output logic              load_busy,
    coef_mem_if.writer        mem
);

    localparam int N = 1 << RING_DEPTH;

    intt_pkg::load_state_e   state;
    logic [RING_DEPTH-1:0]   cnt;       // index of the sample on din
    logic [RING_DEPTH-1:0]   cnt_rev;   // cnt with its bits mirrored

    // control FSM, a new run only starts when the unloader is quiet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= intt_pkg::load_idle;
            cnt   <= '0;
        end else begin
            case (state)
                intt_pkg::load_idle: begin
                    cnt <= '0;
                    if (load && !unload_busy) begin
                        state <= intt_pkg::load_run;
                    end
                end
                intt_pkg::load_run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == RING_DEPTH'(N - 1)) begin  // last sample this cycle
                        state <= intt_pkg::load_idle;
                    end
                end
                default: state <= intt_pkg::load_idle;
            endcase
        end
    end

    // bit-reversed write address
    always_comb begin
        for (int i = 0; i < RING_DEPTH; i++) begin
            cnt_rev[i] = cnt[RING_DEPTH-1-i];
        end
    end

    assign load_busy = (state != intt_pkg::load_idle);

    // din goes straight into the banks, so the write lands on the sampling edge
    assign mem.wen   = (state == intt_pkg::load_run);
    assign mem.waddr = cnt_rev;
    assign mem.wdata = din;

    // an idle loader writes nothing until it takes a load pulse
    a_no_wen_idle: assert property (@(posedge clk) disable iff (reset)
        (state == intt_pkg::load_idle && !(load && !unload_busy)) |=> !mem.wen)
        else $error("coef_loader: write strobe without an accepted load");

endmodule

/* common/coef_mem_if.sv */
`timescale 1ns/1ps

// port between the coefficient banks, the loader and the unloader
interface coef_mem_if #(
    parameter int ADDR_WIDTH = 5
);

    logic                    wen;    // write strobe, takes effect on this edge
    logic [ADDR_WIDTH-1:0]   waddr;  // bit 0 picks the bank
    intt_pkg::coef_t         wdata;
    logic [ADDR_WIDTH-1:0]   raddr;
    intt_pkg::coef_t         rdata;  // one cycle after raddr

    // loader side
    modport writer (output wen, output waddr, output wdata);

    // unloader side
    modport reader (output raddr, input rdata);

    // the banks themselves
    modport store (input wen, input waddr, input wdata, input raddr, output rdata);

endinterface

/* common/intt_pkg.sv */
package intt_pkg;

    // coefficient width, wide enough for the default modulus 7681
    localparam int COEF_WIDTH = 13;

    // one coefficient word, loaded or scaled
    typedef logic [COEF_WIDTH-1:0] coef_t;

    // register stages in the modular multiply: product, then reduction
    localparam int MUL_LATENCY = 2;

    // loader FSM
    typedef enum logic {
        load_idle,     // waiting for a load pulse
        load_run       // one sample per cycle into the banks
    } load_state_e;

    // unloader FSM
    typedef enum logic [1:0] {
        unload_idle,   // waiting for an unload pulse
        unload_read,   // issuing read addresses 0..N-1
        unload_drain   // multiply pipeline emptying
    } unload_state_e;

endpackage
